/* rtl/yags_pkg.sv */
package yags_pkg;

    // branch address, bits 1:0 unused
    typedef logic [31:0] pc_t;

    // 2-bit saturating counter, msb set means taken
    typedef logic [1:0] counter_t;

    // counter encodings
    localparam counter_t ctr_strong_nt = 2'b00;
    localparam counter_t ctr_weak_nt   = 2'b01;
    localparam counter_t ctr_weak_t    = 2'b10;
    localparam counter_t ctr_strong_t  = 2'b11;

    // default table geometry
    localparam int default_index_width = 10;
    localparam int default_ghr_width   = 10;
    localparam int default_tag_width   = 6;

    // one saturating step toward the resolved direction
    function automatic counter_t ctr_next(counter_t ctr, logic taken);
        counter_t result;
        result = ctr;
        if (taken) begin
            // count up, hold at strong taken
            if (ctr != ctr_strong_t) begin
                result = ctr + 2'd1;
            end
        end else begin
            // count down, hold at strong not taken
            if (ctr != ctr_strong_nt) begin
                result = ctr - 2'd1;
            end
        end
        return result;
    endfunction

endpackage

/* rtl/global_history.sv */
`timescale 1ns/1ps

module global_history #(
    parameter int index_width = yags_pkg::default_index_width,
    parameter int ghr_width   = yags_pkg::default_ghr_width,
    parameter int tag_width   = yags_pkg::default_tag_width
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   update_valid,
    input  logic                   update_taken,
    input  yags_pkg::pc_t          lookup_pc,
    input  yags_pkg::pc_t          update_pc,
    output logic [index_width-1:0] lookup_index,
    output logic [index_width-1:0] update_index,
    output logic [tag_width-1:0]   lookup_tag,
    output logic [tag_width-1:0]   update_tag
);

    logic [ghr_width-1:0]   ghr;
    // history fitted to the index width
    logic [index_width-1:0] ghr_fit;

    // newest outcome enters at bit 0
    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
        end else if (update_valid) begin
            ghr <= {ghr[ghr_width-2:0], update_taken};
        end
    end

    // zero-extend or truncate
    assign ghr_fit = index_width'(ghr);

    // word address bits above the byte offset, folded with history
    assign lookup_index = lookup_pc[index_width+1:2] ^ ghr_fit;
    assign update_index = update_pc[index_width+1:2] ^ ghr_fit;

    // tag sits right above the choice index
    assign lookup_tag = lookup_pc[index_width+tag_width+1:index_width+2];
    assign update_tag = update_pc[index_width+tag_width+1:index_width+2];

endmodule

/* rtl/choice_table.sv */
`timescale 1ns/1ps

module choice_table #(
    parameter int index_width = yags_pkg::default_index_width
) (
    input  logic          clk,
    input  logic          reset,
    input  yags_pkg::pc_t lookup_pc,
    input  yags_pkg::pc_t update_pc,
    input  logic          choice_write,
    input  logic          choice_taken,
    output logic          lookup_choice,
    output logic          update_choice
);

    localparam int entries = 2 ** index_width;

    // pc-indexed bias counters
    yags_pkg::counter_t counters [entries];

    logic [index_width-1:0] lookup_idx;
    logic [index_width-1:0] update_idx;

    // word address, no history
    assign lookup_idx = lookup_pc[index_width+1:2];
    assign update_idx = update_pc[index_width+1:2];

    // two combinational read ports
    // only the direction bit leaves the table
    assign lookup_choice = counters[lookup_idx][1];
    assign update_choice = counters[update_idx][1];

    // reset walks the whole array to weak not taken
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < entries; i++) begin
                counters[i] <= yags_pkg::ctr_weak_nt;
            end
        end else if (choice_write) begin
            // saturate toward the resolved direction
            counters[update_idx] <= yags_pkg::ctr_next(counters[update_idx], choice_taken);
        end
    end

endmodule

/* rtl/exception_cache.sv */
`timescale 1ns/1ps

module exception_cache #(
    parameter int index_width = yags_pkg::default_index_width,
    parameter int tag_width   = yags_pkg::default_tag_width
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [index_width-1:0] lookup_index,
    input  logic [index_width-1:0] update_index,
    input  logic [tag_width-1:0]   lookup_tag,
    input  logic [tag_width-1:0]   update_tag,
    input  logic                   counter_step,
    input  logic                   allocate,
    input  logic                   outcome,
    output logic                   lookup_hit,
    output logic                   lookup_dir,
    output logic                   update_hit,
    output logic                   update_dir
);

    localparam int entries = 2 ** index_width;

    // per entry state
    logic [entries-1:0]  valid_q;
    logic [tag_width-1:0] tags_q [entries];
    yags_pkg::counter_t   ctrs_q [entries];

    // counter written by a fresh allocation
    yags_pkg::counter_t   alloc_ctr;

    assign alloc_ctr = outcome ? yags_pkg::ctr_weak_t : yags_pkg::ctr_weak_nt;

    // lookup port
    // a hit needs the valid bit and a full tag match
    assign lookup_hit = valid_q[lookup_index] && (tags_q[lookup_index] == lookup_tag);
    assign lookup_dir = ctrs_q[lookup_index][1];

    // update port, same rule at the resolved address
    assign update_hit = valid_q[update_index] && (tags_q[update_index] == update_tag);
    assign update_dir = ctrs_q[update_index][1];

    // valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (allocate) begin
            valid_q[update_index] <= 1'b1;
        end
    end

    // tag and counter storage
    always_ff @(posedge clk) begin
        if (allocate) begin
            // evicts whatever lived here before
            tags_q[update_index] <= update_tag;
            ctrs_q[update_index] <= alloc_ctr;
        end else if (counter_step) begin
            // nudge the matching entry toward the outcome
            ctrs_q[update_index] <= yags_pkg::ctr_next(ctrs_q[update_index], outcome);
        end
    end

endmodule

/* rtl/prediction_combiner.sv */
`timescale 1ns/1ps

module prediction_combiner (
    input  logic clk,
    input  logic reset,
    input  logic lookup_valid,
    input  logic update_valid,
    input  logic update_taken,
    input  logic lookup_choice,
    input  logic update_choice,
    // taken cache results
    input  logic taken_lookup_hit,
    input  logic taken_lookup_dir,
    input  logic taken_update_hit,
    input  logic taken_update_dir,
    // not-taken cache results
    input  logic not_taken_lookup_hit,
    input  logic not_taken_lookup_dir,
    input  logic not_taken_update_hit,
    input  logic not_taken_update_dir,
    output logic pred_valid,
    output logic pred_taken,
    output logic choice_write,
    output logic choice_taken,
    output logic taken_counter_step,
    output logic taken_allocate,
    output logic taken_outcome,
    output logic not_taken_counter_step,
    output logic not_taken_allocate,
    output logic not_taken_outcome
);

    logic lookup_hit;
    logic lookup_dir;
    logic lookup_pred;
    logic update_hit;
    logic update_dir;
    logic choice_wrong;
    logic cache_correct;
    logic step;
    logic alloc;

    // choice taken looks for not-taken exceptions, and the other way round
    assign lookup_hit  = lookup_choice ? not_taken_lookup_hit : taken_lookup_hit;
    assign lookup_dir  = lookup_choice ? not_taken_lookup_dir : taken_lookup_dir;
    // exception entry wins on a hit
    assign lookup_pred = lookup_hit ? lookup_dir : lookup_choice;

    // one cycle of latency
    always_ff @(posedge clk) begin
        if (reset) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            pred_taken <= lookup_pred;
        end
    end

    // consulted cache at the update address
    assign update_hit   = update_choice ? not_taken_update_hit : taken_update_hit;
    assign update_dir   = update_choice ? not_taken_update_dir : taken_update_dir;
    assign choice_wrong = update_choice != update_taken;
    // choice missed but the exception got it right
    assign cache_correct = choice_wrong && update_hit && (update_dir == update_taken);

    // choice counter is left alone only when the cache covered for it
    assign choice_write = update_valid && !cache_correct;
    assign choice_taken = update_taken;

    assign step  = update_valid && update_hit;
    assign alloc = update_valid && !update_hit && choice_wrong;

    // route writes to the consulted cache only
    assign taken_counter_step     = step && !update_choice;
    assign taken_allocate         = alloc && !update_choice;
    assign not_taken_counter_step = step && update_choice;
    assign not_taken_allocate     = alloc && update_choice;

    assign taken_outcome     = update_taken;
    assign not_taken_outcome = update_taken;

endmodule

/* rtl/yags_predictor.sv */
`timescale 1ns/1ps

module yags_predictor #(
    parameter int index_width = yags_pkg::default_index_width,
    parameter int ghr_width   = yags_pkg::default_ghr_width,
    parameter int tag_width   = yags_pkg::default_tag_width
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          lookup_valid,
    input  yags_pkg::pc_t lookup_pc,
    output logic          pred_valid,
    output logic          pred_taken,
    input  logic          update_valid,
    input  yags_pkg::pc_t update_pc,
    input  logic          update_taken
);

    // hashed fields shared by both caches
    logic [index_width-1:0] lookup_index;
    logic [index_width-1:0] update_index;
    logic [tag_width-1:0]   lookup_tag;
    logic [tag_width-1:0]   update_tag;

    // choice table
    logic lookup_choice;
    logic update_choice;
    logic choice_write;
    logic choice_taken;

    // taken cache
    logic t_lookup_hit;
    logic t_lookup_dir;
    logic t_update_hit;
    logic t_update_dir;
    logic t_counter_step;
    logic t_allocate;
    logic t_outcome;

    // not-taken cache
    logic nt_lookup_hit;
    logic nt_lookup_dir;
    logic nt_update_hit;
    logic nt_update_dir;
    logic nt_counter_step;
    logic nt_allocate;
    logic nt_outcome;

    global_history #(
        .index_width(index_width),
        .ghr_width(ghr_width),
        .tag_width(tag_width)
    ) ghr (
        .clk(clk),
        .reset(reset),
        .update_valid(update_valid),
        .update_taken(update_taken),
        .lookup_pc(lookup_pc),
        .update_pc(update_pc),
        .lookup_index(lookup_index),
        .update_index(update_index),
        .lookup_tag(lookup_tag),
        .update_tag(update_tag)
    );

    choice_table #(
        .index_width(index_width)
    ) choice (
        .clk(clk),
        .reset(reset),
        .lookup_pc(lookup_pc),
        .update_pc(update_pc),
        .choice_write(choice_write),
        .choice_taken(choice_taken),
        .lookup_choice(lookup_choice),
        .update_choice(update_choice)
    );

    // exceptions for branches biased not taken
    exception_cache #(
        .index_width(index_width),
        .tag_width(tag_width)
    ) taken_cache (
        .clk(clk),
        .reset(reset),
        .lookup_index(lookup_index),
        .update_index(update_index),
        .lookup_tag(lookup_tag),
        .update_tag(update_tag),
        .counter_step(t_counter_step),
        .allocate(t_allocate),
        .outcome(t_outcome),
        .lookup_hit(t_lookup_hit),
        .lookup_dir(t_lookup_dir),
        .update_hit(t_update_hit),
        .update_dir(t_update_dir)
    );

    // exceptions for branches biased taken
    exception_cache #(
        .index_width(index_width),
        .tag_width(tag_width)
    ) not_taken_cache (
        .clk(clk),
        .reset(reset),
        .lookup_index(lookup_index),
        .update_index(update_index),
        .lookup_tag(lookup_tag),
        .update_tag(update_tag),
        .counter_step(nt_counter_step),
        .allocate(nt_allocate),
        .outcome(nt_outcome),
        .lookup_hit(nt_lookup_hit),
        .lookup_dir(nt_lookup_dir),
        .update_hit(nt_update_hit),
        .update_dir(nt_update_dir)
    );

    prediction_combiner combiner (
        .clk(clk),
        .reset(reset),
        .lookup_valid(lookup_valid),
        .update_valid(update_valid),
        .update_taken(update_taken),
        .lookup_choice(lookup_choice),
        .update_choice(update_choice),
        .taken_lookup_hit(t_lookup_hit),
        .taken_lookup_dir(t_lookup_dir),
        .taken_update_hit(t_update_hit),
        .taken_update_dir(t_update_dir),
        .not_taken_lookup_hit(nt_lookup_hit),
        .not_taken_lookup_dir(nt_lookup_dir),
        .not_taken_update_hit(nt_update_hit),
        .not_taken_update_dir(nt_update_dir),
        .pred_valid(pred_valid),
        .pred_taken(pred_taken),
        .choice_write(choice_write),
        .choice_taken(choice_taken),
        .taken_counter_step(t_counter_step),
        .taken_allocate(t_allocate),
        .taken_outcome(t_outcome),
        .not_taken_counter_step(nt_counter_step),
        .not_taken_allocate(nt_allocate),
        .not_taken_outcome(nt_outcome)
    );

endmodule

/* testbench/yags_predictor_properties.sv */
`timescale 1ns/1ps

module yags_predictor_properties (
    input logic clk,
    input logic reset,
    input logic lookup_valid,
    input logic pred_valid
);

    // a lookup yields a prediction on the next edge
    property lookup_gives_pred;
        @(posedge clk) (!reset && lookup_valid) |=> pred_valid;
    endproperty

    // no prediction without a lookup
    property idle_gives_no_pred;
        @(posedge clk) (!reset && !lookup_valid) |=> !pred_valid;
    endproperty

    // output stage cleared by reset
    property pred_low_after_reset;
        @(posedge clk) reset |=> !pred_valid;
    endproperty

    lookup_gives_pred_check: assert property (lookup_gives_pred)
        else $error("pred_valid missing one cycle after lookup_valid");
    idle_gives_no_pred_check: assert property (idle_gives_no_pred)
        else $error("pred_valid high without a lookup in the cycle before");
    pred_low_after_reset_check: assert property (pred_low_after_reset)
        else $error("pred_valid high in the cycle after reset");

endmodule

bind yags_predictor yags_predictor_properties props (
    .clk(clk),
    .reset(reset),
    .lookup_valid(lookup_valid),
    .pred_valid(pred_valid)
);

/* testbench/tb_yags_predictor.sv */
`timescale 1ns/1ps

module tb_yags_predictor;

    localparam int index_width = yags_pkg::default_index_width;
    localparam int ghr_width   = yags_pkg::default_ghr_width;
    localparam int tag_width   = yags_pkg::default_tag_width;
    localparam int entries     = 2 ** index_width;

    // far away branch used to push a known history
    localparam yags_pkg::pc_t filler_pc = 32'h0003fffc;

    logic          clk;
    logic          reset;
    logic          lookup_valid;
    yags_pkg::pc_t lookup_pc;
    logic          pred_valid;
    logic          pred_taken;
    logic          update_valid;
    yags_pkg::pc_t update_pc;
    logic          update_taken;

    // reference model state, cache 0 taken exceptions, cache 1 not-taken
    yags_pkg::counter_t   m_choice [entries];
    logic                 m_valid [2][entries];
    logic [tag_width-1:0] m_tag [2][entries];
    yags_pkg::counter_t   m_ctr [2][entries];
    logic [ghr_width-1:0] m_ghr;

    logic [31:0] lfsr_state;
    int          checks;
    int          errors;
    int          tests;
    int          start_checks;
    int          start_errors;

    yags_predictor #(
        .index_width(index_width),
        .ghr_width(ghr_width),
        .tag_width(tag_width)
    ) uut (
        .clk(clk),
        .reset(reset),
        .lookup_valid(lookup_valid),
        .lookup_pc(lookup_pc),
        .pred_valid(pred_valid),
        .pred_taken(pred_taken),
        .update_valid(update_valid),
        .update_pc(update_pc),
        .update_taken(update_taken)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [31:0] value);
        int k;
        value = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // word address bits, no history
    function automatic logic [index_width-1:0] choice_index(input yags_pkg::pc_t pc);
        return pc[index_width+1:2];
    endfunction

    function automatic logic [index_width-1:0] cache_index(input yags_pkg::pc_t pc);
        return pc[index_width+1:2] ^ index_width'(m_ghr);
    endfunction

    function automatic logic [tag_width-1:0] tag_of(input yags_pkg::pc_t pc);
        return pc[index_width+tag_width+1:index_width+2];
    endfunction

    function automatic yags_pkg::counter_t saturate(input yags_pkg::counter_t ctr,
                                                    input logic taken);
        if (taken) begin
            return (ctr == 2'b11) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'b00) ? ctr : ctr - 2'd1;
    endfunction

    task automatic model_reset;
        int i;
        m_ghr = '0;
        for (i = 0; i < entries; i++) begin
            m_choice[i]   = yags_pkg::ctr_weak_nt;
            m_valid[0][i] = 1'b0;
            m_valid[1][i] = 1'b0;
        end
    endtask

    function automatic logic model_predict(input yags_pkg::pc_t pc);
        logic [index_width-1:0] idx;
        logic choice;
        logic hit;
        int sel;
        idx = cache_index(pc);
        choice = m_choice[choice_index(pc)][1];
        // taken choice looks in the not-taken cache
        sel = choice ? 1 : 0;
        hit = m_valid[sel][idx] && (m_tag[sel][idx] == tag_of(pc));
        return hit ? m_ctr[sel][idx][1] : choice;
    endfunction

    task automatic model_update(input yags_pkg::pc_t pc, input logic taken);
        logic [index_width-1:0] ci;
        logic [index_width-1:0] idx;
        logic choice;
        logic hit;
        int sel;
        ci = choice_index(pc);
        idx = cache_index(pc);
        choice = m_choice[ci][1];
        sel = choice ? 1 : 0;
        hit = m_valid[sel][idx] && (m_tag[sel][idx] == tag_of(pc));
        // choice held only when a hit fixed a wrong choice
        if (!(choice != taken && hit && m_ctr[sel][idx][1] == taken)) begin
            m_choice[ci] = saturate(m_choice[ci], taken);
        end
        if (hit) begin
            m_ctr[sel][idx] = saturate(m_ctr[sel][idx], taken);
        end else if (choice != taken) begin
            m_valid[sel][idx] = 1'b1;
            m_tag[sel][idx]   = tag_of(pc);
            m_ctr[sel][idx]   = taken ? yags_pkg::ctr_weak_t : yags_pkg::ctr_weak_nt;
        end
        // history index used above is the pre-shift one
        m_ghr = {m_ghr[ghr_width-2:0], taken};
    endtask

    task automatic apply_reset;
        @(posedge clk);
        reset        <= 1'b1;
        lookup_valid <= 1'b0;
        update_valid <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        model_reset();
    endtask

    // sample at edges only, pred held stable between them
    task automatic wait_prediction(input yags_pkg::pc_t pc, input logic expected);
        int cycles;
        cycles = 0;
        while (!pred_valid && cycles < 4) begin
            @(posedge clk);
            cycles++;
        end
        if (!pred_valid) begin
            $display("timeout: no prediction within 4 cycles for lookup at pc %h", pc);
            errors++;
        end else begin
            checks++;
            assert (pred_taken === expected) else begin
                $display("Fail at time %0t: pc %h predicted %b, expected %b",
                         $time, pc, pred_taken, expected);
                errors++;
            end
        end
    endtask

    task automatic lookup_check(input yags_pkg::pc_t pc, input logic expected);
        @(posedge clk);
        lookup_valid <= 1'b1;
        lookup_pc    <= pc;
        @(posedge clk);
        lookup_valid <= 1'b0;
        wait_prediction(pc, expected);
    endtask

    task automatic drive_update(input yags_pkg::pc_t pc, input logic taken);
        @(posedge clk);
        update_valid <= 1'b1;
        update_pc    <= pc;
        update_taken <= taken;
        model_update(pc, taken);
        @(posedge clk);
        update_valid <= 1'b0;
    endtask

    // lookup and update sampled at the same edge
    task automatic lookup_during_update(input yags_pkg::pc_t pc, input logic taken,
                                        input logic expected);
        @(posedge clk);
        lookup_valid <= 1'b1;
        lookup_pc    <= pc;
        update_valid <= 1'b1;
        update_pc    <= pc;
        update_taken <= taken;
        model_update(pc, taken);
        @(posedge clk);
        lookup_valid <= 1'b0;
        update_valid <= 1'b0;
        wait_prediction(pc, expected);
    endtask

    // all ones history
    task automatic fill_history;
        repeat (ghr_width) drive_update(filler_pc, 1'b1);
    endtask

    task automatic begin_test;
        start_checks = checks;
        start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%s: %0d checks, %0d errors", name, checks - start_checks,
                 errors - start_errors);
    endtask

    task automatic expect_all_not_taken;
        lookup_check(32'h00000000, 1'b0);
        lookup_check(32'h00001000, 1'b0);
        lookup_check(32'h00002468, 1'b0);
        lookup_check(32'h0000fffc, 1'b0);
    endtask

    task automatic test_reset_state;
        begin_test();
        expect_all_not_taken();
        end_test("reset state");
    endtask

    task automatic test_choice_bias;
        begin_test();
        apply_reset();
        drive_update(32'h00000100, 1'b1);
        drive_update(32'h00000100, 1'b1);
        lookup_check(32'h00000100, 1'b1);
        // word 0x43 under history 3 lands on the taken entry of word 0x40
        lookup_check(32'h0000010c, 1'b1);
        lookup_check(32'h00000104, model_predict(32'h00000104));
        end_test("choice bias");
    endtask

    task automatic test_exception_cache;
        begin_test();
        apply_reset();
        drive_update(32'h00000200, 1'b1);
        drive_update(32'h00000200, 1'b1);
        fill_history();
        drive_update(32'h00000200, 1'b0);
        fill_history();
        lookup_check(32'h00000200, 1'b0);
        // other history misses the entry, choice still taken
        drive_update(filler_pc, 1'b0);
        lookup_check(32'h00000200, 1'b1);
        end_test("exception cache");
    endtask

    // evictor takes the shared not-taken entry
    task automatic alias_round(input yags_pkg::pc_t evictor, input yags_pkg::pc_t other);
        drive_update(evictor, 1'b1);
        drive_update(evictor, 1'b0);
        fill_history();
        lookup_check(evictor, model_predict(evictor));
        lookup_check(other, model_predict(other));
    endtask

    task automatic test_tag_aliasing;
        begin_test();
        apply_reset();
        drive_update(32'h00000300, 1'b1);
        drive_update(32'h00000300, 1'b1);
        fill_history();
        // same choice index, tags 0 and 1
        alias_round(32'h00000300, 32'h00001300);
        alias_round(32'h00001300, 32'h00000300);
        alias_round(32'h00000300, 32'h00001300);
        end_test("tag aliasing");
    endtask

    task automatic test_ordering_and_reset;
        begin_test();
        apply_reset();
        lookup_during_update(32'h00000100, 1'b1, 1'b0);
        lookup_check(32'h00000100, 1'b1);
        drive_update(32'h00000100, 1'b1);
        apply_reset();
        expect_all_not_taken();
        // trained branch and its taken-cache entry are gone
        lookup_check(32'h00000100, 1'b0);
        end_test("ordering and reset");
    endtask

    task automatic test_random_stream;
        logic [31:0] r;
        yags_pkg::pc_t pc;
        logic taken;
        int i;
        begin_test();
        apply_reset();
        for (i = 0; i < 200; i++) begin
            // small pool: 8 choice indexes, 4 tags
            take_bits(5, r);
            pc = {18'b0, r[4:3], 7'b0, r[2:0], 2'b00};
            take_bits(1, r);
            taken = r[0];
            lookup_check(pc, model_predict(pc));
            drive_update(pc, taken);
        end
        end_test("random stream");
    endtask

    initial begin
        reset        = 1'b1;
        lookup_valid = 1'b0;
        lookup_pc    = '0;
        update_valid = 1'b0;
        update_pc    = '0;
        update_taken = 1'b0;
        lfsr_state   = 32'hfbbbcb69;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        model_reset();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        test_reset_state();
        test_choice_bias();
        test_exception_cache();
        test_tag_aliasing();
        test_ordering_and_reset();
        test_random_stream();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* yags_predictor.f */
rtl/yags_pkg.sv
rtl/global_history.sv
rtl/choice_table.sv
rtl/exception_cache.sv
rtl/prediction_combiner.sv
rtl/yags_predictor.sv
testbench/yags_predictor_properties.sv
testbench/tb_yags_predictor.sv

/* Makefile */
SIM       := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_yags_predictor
FILELIST  := yags_predictor.f
BUILD_DIR := obj_dir
BINARY    := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	grep -q -x "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
